//--- src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Cache geometry. Four lines of sixteen bytes.
  localparam int offset_bits = 4;
  localparam int index_bits = 2;
  localparam int tag_bits = 32 - offset_bits - index_bits;
  localparam int line_words = 4;

  localparam logic [31:0] reset_pc = 32'h3000_0000;

  // Top address byte of the word-at-a-time region.
  localparam logic [7:0] uncached_page = 8'h0F;

  typedef struct packed {
    logic [tag_bits-1:0]      tag;
    logic [index_bits-1:0]    index;
    logic [offset_bits-3:0]   slot;
    logic [1:0]               byte_off;
  } fetch_fields_t;

  typedef union packed {
    logic [31:0]   raw;
    fetch_fields_t fields;
  } fetch_addr_t;

  typedef enum logic [1:0] {
    state_lookup,
    state_request,
    state_receive,
    state_redirect_wait
  } fetch_state_t;

endpackage

`default_nettype wire

//--- src/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   advance,
  input  wire                   redirect_exception,
  input  wire  [31:0]           exception_pc,
  input  wire                   redirect_flush,
  input  wire  [31:0]           flush_pc,
  output fetch_pkg::fetch_addr_t pc,
  output logic                  pc_uncached,
  output logic                  pc_misaligned,
  output logic                  redirected
);

  import fetch_pkg::*;

  assign redirected = redirect_exception || redirect_flush;

  // An exception target overrides a flush target raised in the same cycle.
  always_ff @(posedge clock) begin
    if (reset) begin
      pc.raw <= reset_pc;
    end else if (redirect_exception) begin
      pc.raw <= exception_pc;
    end else if (redirect_flush) begin
      pc.raw <= flush_pc;
    end else if (advance) begin
      pc.raw <= pc.raw + 32'd4;
    end
  end

  assign pc_uncached = (pc.raw[31:24] == uncached_page);

  // Instructions are word aligned, so any set byte bit is a fault.
  assign pc_misaligned = (pc.fields.byte_off != 2'b00);

endmodule

`default_nettype wire

//--- src/beat_counter.sv
`timescale 1ns/10ps
`default_nettype none

module beat_counter (
  input  wire        clock,
  input  wire        reset,
  input  wire        burst_start,
  input  wire        beat,
  output logic [1:0] beat_slot
);

  import fetch_pkg::*;

  logic [1:0] count;

  // Bursts are always line aligned, so the beat count is the word slot.
  always_ff @(posedge clock) begin
    if (reset || burst_start) begin
      count <= 2'd0;
    end else if (beat) begin
      if (count == 2'(line_words - 1)) begin
        count <= 2'd0;
      end else begin
        count <= count + 2'd1;
      end
    end
  end

  assign beat_slot = count;

endmodule

`default_nettype wire

//--- src/icache_store.sv
`timescale 1ns/10ps
`default_nettype none

module icache_store (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    clear_cache,
  input  wire fetch_pkg::fetch_addr_t pc,
  input  wire                    lookup_enable,
  input  wire                    fill_beat,
  input  wire                    fill_done,
  input  wire  [1:0]             beat_slot,
  input  wire  [31:0]            fill_word,
  output logic                   hit,
  output logic [31:0]            hit_word
);

  import fetch_pkg::*;

  logic [31:0]           data_mem [0:(2**index_bits)*line_words-1];
  logic [tag_bits-1:0]   tag_mem [0:(2**index_bits)-1];
  logic [(2**index_bits)-1:0] line_valid;

  // Line being refilled. It is captured while the controller looks up,
  // so a redirect during the burst does not move the fill target.
  logic [tag_bits-1:0]   fill_tag;
  logic [index_bits-1:0] fill_index;
  logic                  fill_clean;

  assign hit = line_valid[pc.fields.index] &&
               (tag_mem[pc.fields.index] == pc.fields.tag);
  assign hit_word = data_mem[{pc.fields.index, pc.fields.slot}];

  always_ff @(posedge clock) begin
    if (lookup_enable) begin
      fill_tag <= pc.fields.tag;
      fill_index <= pc.fields.index;
    end
    if (fill_beat) begin
      data_mem[{fill_index, beat_slot}] <= fill_word;
    end
    if (fill_done) begin
      tag_mem[fill_index] <= fill_tag;
    end
  end

  // An invalidate seen at any point of a refill keeps the new line invalid.
  always_ff @(posedge clock) begin
    if (reset) begin
      fill_clean <= 1'b0;
    end else if (clear_cache) begin
      fill_clean <= 1'b0;
    end else if (lookup_enable) begin
      fill_clean <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clear_cache) begin
      line_valid <= '0;
    end else if (fill_done) begin
      line_valid[fill_index] <= fill_clean;
    end else if (fill_beat) begin
      // The line holds a mix of old and new words until the last beat.
      line_valid[fill_index] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/fetch_control.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_control (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   idu_ready,
  input  wire fetch_pkg::fetch_addr_t pc,
  input  wire                   pc_uncached,
  input  wire                   pc_misaligned,
  input  wire                   redirected,
  input  wire                   hit,
  input  wire  [31:0]           hit_word,
  input  wire                   arready,
  input  wire  [31:0]           rdata,
  input  wire                   rvalid,
  input  wire                   rlast,
  output logic                  advance,
  output logic                  lookup_enable,
  output logic                  burst_start,
  output logic                  fill_beat,
  output logic                  fill_done,
  output logic                  inst_valid,
  output logic [31:0]           inst,
  output logic [31:0]           inst_pc,
  output logic [31:0]           araddr,
  output logic [7:0]            arlen,
  output logic                  arvalid,
  output logic                  rready,
  output logic                  enable,
  output logic                  inst_addr_misaligned
);

  import fetch_pkg::*;

  fetch_state_t state;
  logic burst_uncached;
  logic burst_stale;
  logic lookup_go;
  logic beat_accept;
  logic deliver_hit;
  logic deliver_uncached;

  assign lookup_enable = (state == state_lookup);
  assign enable = (state == state_request) || (state == state_receive);

  // A redirect in this cycle replaces the PC, so the old one is not acted on.
  assign lookup_go = lookup_enable && idu_ready && !redirected;
  assign deliver_hit = lookup_go && !pc_misaligned && !pc_uncached && hit;
  assign burst_start = lookup_go && !pc_misaligned && !deliver_hit;

  assign beat_accept = rvalid && rready;
  assign fill_beat = beat_accept && !burst_uncached;
  assign fill_done = fill_beat && rlast;
  assign deliver_uncached = beat_accept && burst_uncached && !burst_stale && !redirected;

  assign advance = deliver_hit || deliver_uncached;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= state_lookup;
      arvalid <= 1'b0;
      rready <= 1'b0;
      inst_valid <= 1'b0;
      inst_addr_misaligned <= 1'b0;
      burst_uncached <= 1'b0;
      burst_stale <= 1'b0;
    end else begin
      inst_valid <= advance;
      inst_addr_misaligned <= lookup_go && pc_misaligned;
      case (state)
        state_lookup: begin
          if (lookup_go && pc_misaligned) begin
            state <= state_redirect_wait;
          end else if (burst_start) begin
            arvalid <= 1'b1;
            burst_uncached <= pc_uncached;
            burst_stale <= 1'b0;
            state <= state_request;
          end
        end
        state_request: begin
          if (redirected) begin
            burst_stale <= 1'b1;
          end
          if (arready) begin
            arvalid <= 1'b0;
            rready <= 1'b1;
            state <= state_receive;
          end
        end
        state_receive: begin
          if (redirected) begin
            burst_stale <= 1'b1;
          end
          if (beat_accept && rlast) begin
            rready <= 1'b0;
            state <= state_lookup;
          end
        end
        state_redirect_wait: begin
          if (redirected) begin
            state <= state_lookup;
          end
        end
        default: state <= state_lookup;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (deliver_hit) begin
      inst <= hit_word;
      inst_pc <= pc.raw;
    end else if (deliver_uncached) begin
      inst <= rdata;
      inst_pc <= pc.raw;
    end
    if (burst_start) begin
      araddr <= pc_uncached ? pc.raw : {pc.raw[31:offset_bits], {offset_bits{1'b0}}};
      arlen <= pc_uncached ? 8'd0 : 8'(line_words - 1);
    end
  end

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
  input  wire         clock,
  input  wire         reset,
  output logic        inst_valid,
  output logic [31:0] inst,
  output logic [31:0] inst_pc,
  input  wire         idu_ready,
  input  wire         redirect_exception,
  input  wire  [31:0] exception_pc,
  input  wire         redirect_flush,
  input  wire  [31:0] flush_pc,
  input  wire         clear_cache,
  output logic        inst_addr_misaligned,
  output logic        enable,
  output logic [31:0] araddr,
  output logic [7:0]  arlen,
  output logic        arvalid,
  input  wire         arready,
  output logic        rready,
  input  wire  [31:0] rdata,
  input  wire         rvalid,
  input  wire         rlast
);

  import fetch_pkg::*;

  fetch_addr_t pc;
  wire         pc_uncached;
  wire         pc_misaligned;
  wire         redirected;
  wire         advance;
  wire         hit;
  wire  [31:0] hit_word;
  wire         lookup_enable;
  wire         burst_start;
  wire         fill_beat;
  wire         fill_done;
  wire  [1:0]  beat_slot;

  pc_unit pc_reg (
    .clock(clock),
    .reset(reset),
    .advance(advance),
    .redirect_exception(redirect_exception),
    .exception_pc(exception_pc),
    .redirect_flush(redirect_flush),
    .flush_pc(flush_pc),
    .pc(pc),
    .pc_uncached(pc_uncached),
    .pc_misaligned(pc_misaligned),
    .redirected(redirected)
  );

  // Only cached beats advance the slot count.
  beat_counter beats (
    .clock(clock),
    .reset(reset),
    .burst_start(burst_start),
    .beat(fill_beat),
    .beat_slot(beat_slot)
  );

  icache_store cache (
    .clock(clock),
    .reset(reset),
    .clear_cache(clear_cache),
    .pc(pc),
    .lookup_enable(lookup_enable),
    .fill_beat(fill_beat),
    .fill_done(fill_done),
    .beat_slot(beat_slot),
    .fill_word(rdata),
    .hit(hit),
    .hit_word(hit_word)
  );

  fetch_control control (
    .clock(clock),
    .reset(reset),
    .idu_ready(idu_ready),
    .pc(pc),
    .pc_uncached(pc_uncached),
    .pc_misaligned(pc_misaligned),
    .redirected(redirected),
    .hit(hit),
    .hit_word(hit_word),
    .arready(arready),
    .rdata(rdata),
    .rvalid(rvalid),
    .rlast(rlast),
    .advance(advance),
    .lookup_enable(lookup_enable),
    .burst_start(burst_start),
    .fill_beat(fill_beat),
    .fill_done(fill_done),
    .inst_valid(inst_valid),
    .inst(inst),
    .inst_pc(inst_pc),
    .araddr(araddr),
    .arlen(arlen),
    .arvalid(arvalid),
    .rready(rready),
    .enable(enable),
    .inst_addr_misaligned(inst_addr_misaligned)
  );

endmodule

`default_nettype wire

//--- testbench/read_memory_model.sv
`timescale 1ns/10ps
`default_nettype none

module read_memory_model (
  input  wire         clock,
  input  wire         reset,
  input  wire  [31:0] araddr,
  input  wire  [7:0]  arlen,
  input  wire         arvalid,
  output logic        arready,
  input  wire         rready,
  output logic [31:0] rdata,
  output logic        rvalid,
  output logic        rlast,
  output logic [31:0] req_count,
  output logic [31:0] last_addr,
  output logic [7:0]  last_len
);

  logic [31:0] req_addr [$];
  logic        busy = 1'b0;
  logic [31:0] base = 32'd0;
  logic [7:0]  len = 8'd0;
  logic [7:0]  beat = 8'd0;

  // Every word of memory reads as its own address with the upper half scrambled.
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr ^ 32'hA5A5_0000;
  endfunction

  initial begin
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = 32'd0;
    req_count = 32'd0;
    last_addr = 32'd0;
    last_len = 8'd0;
  end

  always @(posedge clock) begin
    if (reset) begin
      busy = 1'b0;
      beat = 8'd0;
      req_addr.delete();
      req_count = 32'd0;
    end else begin
      if (rvalid && rready) begin
        if (rlast) begin
          busy = 1'b0;
        end
        beat = beat + 8'd1;
      end
      if (arvalid && arready) begin
        req_addr.push_back(araddr);
        req_count = req_addr.size();
        last_addr = araddr;
        last_len = arlen;
        busy = 1'b1;
        base = araddr;
        len = arlen;
        beat = 8'd0;
      end
    end
  end

  // One burst at a time, so the address channel only opens while idle.
  always @(negedge clock) begin
    arready = !busy && ($urandom_range(3, 0) != 0);
    rvalid = busy && ($urandom_range(3, 0) != 0);
    rlast = busy && (beat == len);
    rdata = busy ? word_at(base + 32'({beat, 2'b00})) : 32'd0;
  end

endmodule

`default_nettype wire

//--- testbench/fetch_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

  logic        clock;
  logic        reset;
  logic        idu_ready;
  logic        redirect_exception;
  logic [31:0] exception_pc;
  logic        redirect_flush;
  logic [31:0] flush_pc;
  logic        clear_cache;
  wire         inst_valid;
  wire  [31:0] inst;
  wire  [31:0] inst_pc;
  wire         inst_addr_misaligned;
  wire         enable;
  wire  [31:0] araddr;
  wire  [7:0]  arlen;
  wire         arvalid;
  wire         arready;
  wire         rready;
  wire  [31:0] rdata;
  wire         rvalid;
  wire         rlast;
  wire  [31:0] req_count;
  wire  [31:0] last_addr;
  wire  [7:0]  last_len;

  // One entry per delivered instruction, with the bus request state at that moment.
  logic [31:0] got_pc [$];
  logic [31:0] got_req [$];
  logic [31:0] got_addr [$];
  logic [7:0]  got_len [$];
  int          errors;
  int          test_errors;
  int          tests_failed;
  int          misaligned_seen;
  int          req_before;
  int          pulses_before;
  logic        lookup_stalled;

  fetch_top uut (
    .clock(clock), .reset(reset),
    .inst_valid(inst_valid), .inst(inst), .inst_pc(inst_pc), .idu_ready(idu_ready),
    .redirect_exception(redirect_exception), .exception_pc(exception_pc),
    .redirect_flush(redirect_flush), .flush_pc(flush_pc), .clear_cache(clear_cache),
    .inst_addr_misaligned(inst_addr_misaligned), .enable(enable),
    .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
    .rready(rready), .rdata(rdata), .rvalid(rvalid), .rlast(rlast)
  );

  read_memory_model bus (
    .clock(clock), .reset(reset),
    .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
    .rready(rready), .rdata(rdata), .rvalid(rvalid), .rlast(rlast),
    .req_count(req_count), .last_addr(last_addr), .last_len(last_len)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("mismatch %s: got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s never came", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  // Outputs are stable before the edge, so the monitor reads them there.
  always @(posedge clock) begin
    if (reset) begin
      lookup_stalled = 1'b0;
    end else begin
      // A bus transaction is open from the arvalid rise to the last beat.
      check_value("enable", 32'(enable), 32'(arvalid || rready));
      if (inst_valid) begin
        assert (!lookup_stalled) else begin
          $display("inst_valid followed a lookup edge with idu_ready low, pc %h", inst_pc);
          errors++;
        end
        check_value("inst", inst, inst_pc ^ 32'hA5A5_0000);
        got_pc.push_back(inst_pc);
        got_req.push_back(req_count);
        got_addr.push_back(last_addr);
        got_len.push_back(last_len);
      end
      if (inst_addr_misaligned) begin
        misaligned_seen++;
      end
      lookup_stalled = !enable && !idu_ready;
    end
  end

  task automatic wait_deliveries(input int count, input bit shuffle_ready, input string what);
    int cycles;
    cycles = 0;
    while (got_pc.size() < count && cycles < 2000) begin
      @(negedge clock);
      if (shuffle_ready) begin
        idu_ready = ($urandom_range(1, 0) == 1);
      end
      cycles++;
    end
    if (got_pc.size() < count) begin
      stop_on_timeout(what);
    end
  endtask

  task automatic wait_misaligned(input int count);
    int cycles;
    cycles = 0;
    while (misaligned_seen < count && cycles < 100) begin
      @(negedge clock);
      cycles++;
    end
    if (misaligned_seen < count) begin
      stop_on_timeout("inst_addr_misaligned pulse");
    end
  endtask

  // Stops fetching and lets any open burst drain and its instruction be recorded.
  task automatic wait_idle();
    int cycles;
    idu_ready = 1'b0;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while ((enable || inst_valid) && cycles < 500);
    if (enable || inst_valid) begin
      stop_on_timeout("end of the open bus burst");
    end
  endtask

  task automatic send_redirect(input bit exception, input logic [31:0] exc_target,
                               input bit flush, input logic [31:0] flush_target);
    @(negedge clock);
    redirect_exception = exception;
    exception_pc = exc_target;
    redirect_flush = flush;
    flush_pc = flush_target;
    @(negedge clock);
    redirect_exception = 1'b0;
    redirect_flush = 1'b0;
  endtask

  task automatic start_test();
    got_pc.delete();
    got_req.delete();
    got_addr.delete();
    got_len.delete();
    req_before = req_count;
    pulses_before = misaligned_seen;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - test_errors);
      tests_failed++;
    end
  endtask

  initial begin
    void'($urandom(32'h78117c76));
    reset = 1'b1;
    idu_ready = 1'b0;
    redirect_exception = 1'b0;
    exception_pc = 32'd0;
    redirect_flush = 1'b0;
    flush_pc = 32'd0;
    clear_cache = 1'b0;
    errors = 0;
    tests_failed = 0;
    misaligned_seen = 0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    start_test();
    idu_ready = 1'b1;
    wait_deliveries(4, 1'b0, "first line delivery");
    check_value("araddr", got_addr[0], 32'h3000_0000);
    check_value("arlen", 32'(got_len[0]), 32'd3);
    for (int i = 0; i < 4; i++) begin
      check_value("inst_pc", got_pc[i], 32'h3000_0000 + 32'(4 * i));
    end
    check_value("request count", got_req[3], 32'd1);
    wait_idle();
    end_test("cold start");

    start_test();
    send_redirect(1'b0, 32'd0, 1'b1, 32'h0F00_0010);
    idu_ready = 1'b1;
    wait_deliveries(3, 1'b0, "uncached delivery");
    for (int i = 0; i < 3; i++) begin
      check_value("inst_pc", got_pc[i], 32'h0F00_0010 + 32'(4 * i));
      check_value("araddr", got_addr[i], 32'h0F00_0010 + 32'(4 * i));
      check_value("arlen", 32'(got_len[i]), 32'd0);
      check_value("request count", got_req[i], 32'(req_before + i + 1));
    end
    wait_idle();
    start_test();
    send_redirect(1'b0, 32'd0, 1'b1, 32'h0F00_0010);
    idu_ready = 1'b1;
    wait_deliveries(1, 1'b0, "uncached revisit");
    check_value("araddr", got_addr[0], 32'h0F00_0010);
    check_value("request count", got_req[0], 32'(req_before + 1));
    wait_idle();
    end_test("uncached region");

    start_test();
    send_redirect(1'b1, 32'h3000_0010, 1'b1, 32'h3000_0040);
    idu_ready = 1'b1;
    wait_deliveries(1, 1'b0, "delivery after both redirects");
    check_value("inst_pc", got_pc[0], 32'h3000_0010);
    wait_idle();
    end_test("redirect priority");

    start_test();
    @(negedge clock);
    clear_cache = 1'b1;
    @(negedge clock);
    clear_cache = 1'b0;
    send_redirect(1'b0, 32'd0, 1'b1, 32'h3000_0000);
    idu_ready = 1'b1;
    wait_deliveries(1, 1'b0, "delivery after invalidate");
    check_value("inst_pc", got_pc[0], 32'h3000_0000);
    check_value("araddr", got_addr[0], 32'h3000_0000);
    check_value("arlen", 32'(got_len[0]), 32'd3);
    check_value("request count", got_req[0], 32'(req_before + 1));
    wait_idle();
    end_test("invalidate");

    start_test();
    send_redirect(1'b0, 32'd0, 1'b1, 32'h3000_0002);
    idu_ready = 1'b1;
    wait_misaligned(pulses_before + 1);
    // Nothing may move while the controller waits for a new target.
    repeat (10) @(negedge clock);
    check_value("misaligned pulses", 32'(misaligned_seen - pulses_before), 32'd1);
    check_value("request count", req_count, 32'(req_before));
    check_value("deliveries", 32'(got_pc.size()), 32'd0);
    send_redirect(1'b0, 32'd0, 1'b1, 32'h3000_0004);
    wait_deliveries(1, 1'b0, "delivery after aligned redirect");
    check_value("inst_pc", got_pc[0], 32'h3000_0004);
    wait_idle();
    end_test("misaligned target");

    start_test();
    send_redirect(1'b0, 32'd0, 1'b1, 32'h3000_0100);
    wait_deliveries(24, 1'b1, "deliveries under back-pressure");
    for (int i = 0; i < 24; i++) begin
      check_value("inst_pc", got_pc[i], 32'h3000_0100 + 32'(4 * i));
    end
    wait_idle();
    end_test("back-pressure and stalls");

    $display("tests: 6 run, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
src/fetch_pkg.sv
src/pc_unit.sv
src/beat_counter.sv
src/icache_store.sv
src/fetch_control.sv
src/fetch_top.sv
testbench/read_memory_model.sv
testbench/fetch_tb.sv
